// ==== board_cfg_pkg.sv ====
package board_cfg_pkg;

  // board control defaults, top level overrides these per instance

  // push buttons on the board, all active low at the pins
  localparam int num_buttons = 4;

  // timer driven leds, taken from the top timer bits
  localparam int led_width = 4;

  // ltssm state from the pcie hard ip
  localparam int ltssm_width = 5;

  // low nibble of ltssm when the link sits in L0
  localparam logic [3:0] ltssm_l0 = 4'hf;

  // free-running timer width
  // 40 bits at 100 MHz gives a slow visible walk on the top bits
  localparam int default_timer_width = 40;

  // debounce hold time in clocks
  localparam int default_debounce_cycles = 100000;  // 1 ms at 100 MHz

  // reset request pulse lengths, in clocks
  localparam int default_cold_pulse = 6;
  localparam int default_warm_pulse = 2;
  localparam int default_debug_pulse = 32;  // debug needs the longest pulse

endpackage

// ==== board_ctrl_top.sv ====
`timescale 1ns/1ps

module board_ctrl_top #(
  parameter int TIMER_WIDTH     = board_cfg_pkg::default_timer_width,
  parameter int DEBOUNCE_CYCLES = board_cfg_pkg::default_debounce_cycles,
  parameter int COLD_PULSE      = board_cfg_pkg::default_cold_pulse,
  parameter int WARM_PULSE      = board_cfg_pkg::default_warm_pulse,
  parameter int DEBUG_PULSE     = board_cfg_pkg::default_debug_pulse
) (
  input  logic                                  coreclk_fanout_clk,
  input  logic                                  coreclk_fanout_reset_n,
  // buttons, raw in and debounced out
  input  logic [board_cfg_pkg::num_buttons-1:0] buttons_n,
  output logic [board_cfg_pkg::num_buttons-1:0] buttons,
  // reset requests, levels in and pulses out
  input  board_types_pkg::reset_req_t           reset_req,
  output board_types_pkg::reset_req_t           reset_pulse,
  // pcie link state for the link led
  input  logic [board_cfg_pkg::ltssm_width-1:0] ltssm_state,
  output board_types_pkg::led_out_t             leds
);

  // button input side
  button_debounce #(
    .WIDTH  (board_cfg_pkg::num_buttons),
    .CYCLES (DEBOUNCE_CYCLES)
  ) u_debounce (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .buttons_n              (buttons_n),
    .buttons                (buttons)
  );

  // one pulse generator per reset kind
  // same block, only the length differs
  reset_pulse_gen #(
    .PULSE_LEN (COLD_PULSE)
  ) u_cold (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .req                    (reset_req.cold),
    .pulse                  (reset_pulse.cold)
  );

  reset_pulse_gen #(
    .PULSE_LEN (WARM_PULSE)
  ) u_warm (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .req                    (reset_req.warm),
    .pulse                  (reset_pulse.warm)
  );

  reset_pulse_gen #(
    .PULSE_LEN (DEBUG_PULSE)  // longest of the three
  ) u_debug (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .req                    (reset_req.debug),
    .pulse                  (reset_pulse.debug)
  );

  // status leds, timer bank plus heartbeat and link
  led_status #(
    .TIMER_WIDTH (TIMER_WIDTH)
  ) u_leds (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .ltssm_state            (ltssm_state),
    .leds                   (leds)
  );

endmodule

// ==== board_types_pkg.sv ====
package board_types_pkg;

  // one bit per reset kind
  // used for the request levels in and the pulses out
  typedef struct packed {
    logic cold;   // cold reset
    logic warm;   // warm reset
    logic debug;  // debug reset
  } reset_req_t;

  // everything shown on the status leds
  typedef struct packed {
    logic [board_cfg_pkg::led_width-1:0] bank;  // top timer bits
    logic heartbeat;  // timer msb, one clock late
    logic link;       // 1 while link is not in L0
  } led_out_t;

endpackage

// ==== button_debounce.sv ====
`timescale 1ns/1ps

module button_debounce #(
  parameter int WIDTH  = board_cfg_pkg::num_buttons,
  parameter int CYCLES = board_cfg_pkg::default_debounce_cycles
) (
  input  logic             coreclk_fanout_clk,
  input  logic             coreclk_fanout_reset_n,
  input  logic [WIDTH-1:0] buttons_n,  // raw pins, active low
  output logic [WIDTH-1:0] buttons     // debounced, 1 = pressed
);

  // counter must hold CYCLES-1 at least
  localparam int CNT_W = $clog2(CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES - 1);

  logic [WIDTH-1:0] sync_q1;  // first sync stage, may go metastable
  logic [WIDTH-1:0] sync_q2;  // second stage, safe to use
  logic [WIDTH-1:0] pressed;  // synced level, active high
  logic [WIDTH-1:0] differs;  // synced level not yet on the output

  logic [WIDTH-1:0][CNT_W-1:0] cnt;  // one stability counter per button

  // two-flop synchronizer
  // resets to released so nothing looks pressed after reset
  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      sync_q1 <= '1;
      sync_q2 <= '1;
    end else begin
      sync_q1 <= buttons_n;
      sync_q2 <= sync_q1;
    end
  end

  assign pressed = ~sync_q2;          // flip polarity once here
  assign differs = pressed ^ buttons; // per bit mismatch

  // stability counters and output state
  // a bit flips only after CYCLES mismatching clocks in a row,
  // any agreeing clock throws the count away
  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      cnt     <= '0;
      buttons <= '0;  // not pressed
    end else begin
      for (int i = 0; i < WIDTH; i++) begin
        if (!differs[i]) begin
          cnt[i] <= '0;  // level agrees, nothing pending
        end else if (cnt[i] == CNT_LAST) begin
          buttons[i] <= pressed[i];  // held long enough, release it
          cnt[i]     <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== led_status.sv ====
`timescale 1ns/1ps

module led_status #(
  parameter int TIMER_WIDTH = board_cfg_pkg::default_timer_width
) (
  input  logic                                  coreclk_fanout_clk,
  input  logic                                  coreclk_fanout_reset_n,
  input  logic [board_cfg_pkg::ltssm_width-1:0] ltssm_state,
  output board_types_pkg::led_out_t             leds
);

  localparam int LED_W = board_cfg_pkg::led_width;

  logic [TIMER_WIDTH-1:0] timer;        // free running
  logic                   heartbeat_q;  // msb, one clock behind
  logic                   link_q;       // 1 = not in L0
  logic                   not_l0;

  // only the low nibble carries the L0 code
  assign not_l0 = (ltssm_state[3:0] != board_cfg_pkg::ltssm_l0);

  // timer runs every clock, wraps on its own
  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      timer <= '0;
    end else begin
      timer <= timer + 1'b1;
    end
  end

  // heartbeat and link flops
  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      heartbeat_q <= 1'b0;
      link_q      <= 1'b0;
    end else begin
      heartbeat_q <= timer[TIMER_WIDTH-1];
      link_q      <= not_l0;
    end
  end

  // bank straight off the timer, no extra flop
  always_comb begin
    leds.bank      = timer[TIMER_WIDTH-1 -: LED_W];
    leds.heartbeat = heartbeat_q;
    leds.link      = link_q;
  end

endmodule

// ==== reset_pulse_gen.sv ====
`timescale 1ns/1ps

module reset_pulse_gen #(
  parameter int PULSE_LEN = board_cfg_pkg::default_cold_pulse
) (
  input  logic coreclk_fanout_clk,
  input  logic coreclk_fanout_reset_n,
  input  logic req,    // request level
  output logic pulse   // active high, PULSE_LEN clocks
);

  // wide enough for PULSE_LEN-1, and never zero bits
  localparam int CNT_W = $clog2(PULSE_LEN + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_LEN - 1);

  logic             req_q;  // request one clock ago
  logic             rise;   // rising edge seen this clock
  logic [CNT_W-1:0] cnt;    // clocks left after the current one

  // edge against the registered copy
  assign rise = req & ~req_q;

  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // down-counter holds the pulse
  // edges while pulse is high are dropped, not queued
  always_ff @(posedge coreclk_fanout_clk or negedge coreclk_fanout_reset_n) begin
    if (!coreclk_fanout_reset_n) begin
      pulse <= 1'b0;
      cnt   <= '0;
    end else if (pulse) begin
      if (cnt == '0) begin
        pulse <= 1'b0;  // last clock of the pulse done
      end else begin
        cnt <= cnt - 1'b1;
      end
    end else if (rise) begin
      pulse <= 1'b1;
      cnt   <= CNT_LOAD;  // first clock counts as one
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the board control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_board_ctrl \
  -o sim_board > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_board > sim.log 2>&1

grep -q "Simulation PASSED" sim.log && echo "run passed" && exit 0 || {
  echo "run failed, see sim.log"
  exit 1
}

// ==== sources.f ====
board_cfg_pkg.sv
board_types_pkg.sv
button_debounce.sv
reset_pulse_gen.sv
led_status.sv
board_ctrl_top.sv
tb_board_assert.sv
tb_board_checker.sv
tb_board_ctrl.sv

// ==== tb_board_assert.sv ====
`timescale 1ns/1ps

module tb_board_assert #(
  parameter int COLD_PULSE  = board_cfg_pkg::default_cold_pulse,
  parameter int WARM_PULSE  = board_cfg_pkg::default_warm_pulse,
  parameter int DEBUG_PULSE = board_cfg_pkg::default_debug_pulse
) (
  input logic                        coreclk_fanout_clk,
  input logic                        coreclk_fanout_reset_n,
  input board_types_pkg::reset_req_t reset_pulse,
  input board_types_pkg::led_out_t   leds
);

  // no pulse may leave while reset is held
  a_pulse_reset: assert property (@(posedge coreclk_fanout_clk)
    !coreclk_fanout_reset_n |-> reset_pulse == '0)
    else $error("reset pulse active during reset");

  // falling edge must close a run of exactly LEN clocks
  a_cold_len: assert property (@(posedge coreclk_fanout_clk)
    disable iff (!coreclk_fanout_reset_n)
    $fell(reset_pulse.cold) |->
      $past(reset_pulse.cold, COLD_PULSE) && !$past(reset_pulse.cold, COLD_PULSE + 1))
    else $error("cold pulse length wrong");

  a_warm_len: assert property (@(posedge coreclk_fanout_clk)
    disable iff (!coreclk_fanout_reset_n)
    $fell(reset_pulse.warm) |->
      $past(reset_pulse.warm, WARM_PULSE) && !$past(reset_pulse.warm, WARM_PULSE + 1))
    else $error("warm pulse length wrong");

  a_debug_len: assert property (@(posedge coreclk_fanout_clk)
    disable iff (!coreclk_fanout_reset_n)
    $fell(reset_pulse.debug) |->
      $past(reset_pulse.debug, DEBUG_PULSE) && !$past(reset_pulse.debug, DEBUG_PULSE + 1))
    else $error("debug pulse length wrong");

  // status flops cleared by reset
  a_led_reset: assert property (@(posedge coreclk_fanout_clk)
    !coreclk_fanout_reset_n |-> !leds.heartbeat && !leds.link)
    else $error("heartbeat or link set during reset");

endmodule

bind board_ctrl_top tb_board_assert #(
  .COLD_PULSE  (COLD_PULSE),
  .WARM_PULSE  (WARM_PULSE),
  .DEBUG_PULSE (DEBUG_PULSE)
) u_assert (
  .coreclk_fanout_clk     (coreclk_fanout_clk),
  .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
  .reset_pulse            (reset_pulse),
  .leds                   (leds)
);

// ==== tb_board_checker.sv ====
`timescale 1ns/1ps

module tb_board_checker #(
  parameter int TIMER_WIDTH     = 12,
  parameter int DEBOUNCE_CYCLES = 16
) (
  input logic                                  coreclk_fanout_clk,
  input logic                                  coreclk_fanout_reset_n,
  input logic [board_cfg_pkg::num_buttons-1:0] buttons_n,
  input logic [board_cfg_pkg::num_buttons-1:0] buttons,
  input board_types_pkg::reset_req_t           reset_req,
  input board_types_pkg::reset_req_t           reset_pulse,
  input logic [board_cfg_pkg::ltssm_width-1:0] ltssm_state,
  input board_types_pkg::led_out_t             leds
);

  localparam int NB    = board_cfg_pkg::num_buttons;
  localparam int LED_W = board_cfg_pkg::led_width;

  int error_count = 0;
  int check_count = 0;
  int pulse_count [3];
  int cycles;           // clocks since reset release
  logic [board_cfg_pkg::ltssm_width-1:0] prev_ltssm;
  logic have_prev;
  // per reset field in the order cold warm debug
  logic prev_req [3];
  logic prev_pulse [3];
  logic pending [3];    // edge seen and pulse owed
  int wait_cnt [3];
  int run_len [3];
  // per button
  logic prev_raw [NB];
  logic prev_btn [NB];
  logic late_seen [NB];
  int held [NB];        // clocks the raw level has been stable
  string field_name [3] = '{"cold", "warm", "debug"};

  // expected bank from the top bits of the wrapped count
  function automatic logic [LED_W-1:0] ref_bank(input int n);
    int t;
    t = n % (1 << TIMER_WIDTH);
    return LED_W'((t >> (TIMER_WIDTH - LED_W)) & ((1 << LED_W) - 1));
  endfunction

  // msb of the count one clock back
  function automatic logic ref_heartbeat(input int n);
    int t;
    if (n == 0) return 1'b0;
    t = (n - 1) % (1 << TIMER_WIDTH);
    return ((t >> (TIMER_WIDTH - 1)) & 1) != 0;
  endfunction

  function automatic logic ref_link(input logic [board_cfg_pkg::ltssm_width-1:0] s);
    return s[3:0] != board_cfg_pkg::ltssm_l0;  // L0 code in the low nibble
  endfunction

  function automatic int ref_pulse_len(input int f);
    case (f)
      0:       return 6;
      1:       return 2;
      default: return 32;
    endcase
  endfunction

  task automatic fail_value(input string name, input int exp, input int act);
    $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    error_count++;
  endtask

  task automatic fail_text(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
  endtask

  // all compares on the falling edge where inputs and outputs are settled
  always @(negedge coreclk_fanout_clk) begin
    if (!coreclk_fanout_reset_n) begin
      check_count++;
      if (buttons != '0) fail_value("reset_buttons", 0, int'(buttons));
      if (reset_pulse != '0) fail_value("reset_pulse", 0, int'(reset_pulse));
      if (leds != '0) fail_value("reset_leds", 0, int'(leds));
      cycles    = 0;
      have_prev = 1'b0;
      for (int f = 0; f < 3; f++) begin
        prev_req[f]   = 1'b0;
        prev_pulse[f] = 1'b0;
        pending[f]    = 1'b0;
        wait_cnt[f]   = 0;
        run_len[f]    = 0;
      end
      for (int i = 0; i < NB; i++) begin
        prev_raw[i]  = 1'b0;
        prev_btn[i]  = 1'b0;
        late_seen[i] = 1'b0;
        held[i]      = 0;
      end
    end else begin
      // led bank plus heartbeat and link
      check_count++;
      if (leds.bank != ref_bank(cycles))
        fail_value("led_bank", int'(ref_bank(cycles)), int'(leds.bank));
      if (leds.heartbeat != ref_heartbeat(cycles))
        fail_value("heartbeat", int'(ref_heartbeat(cycles)), int'(leds.heartbeat));
      if (have_prev && leds.link != ref_link(prev_ltssm))
        fail_value("link", int'(ref_link(prev_ltssm)), int'(leds.link));
      prev_ltssm = ltssm_state;
      have_prev  = 1'b1;
      cycles++;

      // reset pulses with struct bit 2 as cold
      for (int f = 0; f < 3; f++) begin
        if (reset_pulse[2-f] && !prev_pulse[f]) begin
          if (pending[f]) pending[f] = 1'b0;
          else fail_text({"unexpected pulse on ", field_name[f]});
          run_len[f] = 1;
          pulse_count[f]++;
        end else if (reset_pulse[2-f]) begin
          run_len[f]++;
        end else if (prev_pulse[f]) begin
          check_count++;
          if (run_len[f] != ref_pulse_len(f))
            fail_value({"pulse_len_", field_name[f]}, ref_pulse_len(f), run_len[f]);
        end
        if (pending[f]) begin
          wait_cnt[f]++;
          if (wait_cnt[f] > 3) begin
            fail_text({"missing pulse on ", field_name[f]});
            pending[f] = 1'b0;
          end
        end
        // edge counts only while idle
        if (reset_req[2-f] && !prev_req[f] && !reset_pulse[2-f]) begin
          pending[f]  = 1'b1;
          wait_cnt[f] = 0;
        end
        prev_req[f]   = reset_req[2-f];
        prev_pulse[f] = reset_pulse[2-f];
      end

      // debounce window of D to D+4 stable clocks before a flip
      for (int i = 0; i < NB; i++) begin
        if (!buttons_n[i] != prev_raw[i]) held[i] = 0;
        else held[i]++;
        prev_raw[i] = !buttons_n[i];
        if (buttons[i] != prev_btn[i]) begin
          check_count++;
          late_seen[i] = 1'b0;
          if (buttons[i] != prev_raw[i] || held[i] < DEBOUNCE_CYCLES ||
              held[i] > DEBOUNCE_CYCLES + 4)
            fail_value($sformatf("debounce_b%0d", i), DEBOUNCE_CYCLES, held[i]);
        end else if (buttons[i] != prev_raw[i] && held[i] > DEBOUNCE_CYCLES + 4 &&
                     !late_seen[i]) begin
          fail_text($sformatf("button %0d never took its held level", i));
          late_seen[i] = 1'b1;
        end
        prev_btn[i] = buttons[i];
      end
    end
  end

endmodule

// ==== tb_board_ctrl.sv ====
`timescale 1ns/1ps

module tb_board_ctrl;

  localparam int TIMER_WIDTH     = 12;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int NB              = board_cfg_pkg::num_buttons;

  logic                               coreclk_fanout_clk;
  logic                               coreclk_fanout_reset_n;
  logic [NB-1:0]                      buttons_n;
  logic [NB-1:0]                      buttons;
  board_types_pkg::reset_req_t        reset_req;
  board_types_pkg::reset_req_t        reset_pulse;
  logic [board_cfg_pkg::ltssm_width-1:0] ltssm_state;
  board_types_pkg::led_out_t          leds;

  logic [31:0] seed;
  int          timeouts;

  board_ctrl_top #(
    .TIMER_WIDTH     (TIMER_WIDTH),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) UUT (
    .coreclk_fanout_clk     (coreclk_fanout_clk),
    .coreclk_fanout_reset_n (coreclk_fanout_reset_n),
    .buttons_n              (buttons_n),
    .buttons                (buttons),
    .reset_req              (reset_req),
    .reset_pulse            (reset_pulse),
    .ltssm_state            (ltssm_state),
    .leds                   (leds)
  );

  tb_board_checker #(
    .TIMER_WIDTH     (TIMER_WIDTH),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_checker (.*);

  always #20 coreclk_fanout_clk = ~coreclk_fanout_clk;  // 40 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    seed = xorshift32(seed);
    r    = seed;
  endtask

  // bounded wait for the debounced outputs
  task automatic wait_buttons(input logic [NB-1:0] exp, input int limit);
    int t;
    t = 0;
    while (buttons != exp && t < limit) begin
      @(posedge coreclk_fanout_clk);
      t++;
    end
    if (buttons != exp) begin
      $display("timeout waiting for buttons %b, still %b", exp, buttons);
      timeouts++;
    end
  endtask

  // bounded wait for one pulse bit to reach a level
  task automatic wait_pulse(input int bitpos, input logic lvl, input int limit);
    logic [2:0] pv;
    int t;
    t  = 0;
    pv = reset_pulse;
    while (pv[bitpos] != lvl && t < limit) begin
      @(posedge coreclk_fanout_clk);
      pv = reset_pulse;
      t++;
    end
    if (pv[bitpos] != lvl) begin
      $display("timeout waiting for reset pulse bit %0d to go %b", bitpos, lvl);
      timeouts++;
    end
  endtask

  task automatic hold_press(input logic [NB-1:0] pat);
    @(posedge coreclk_fanout_clk);
    buttons_n <= ~pat;
    repeat (40) @(posedge coreclk_fanout_clk);
    wait_buttons(pat, 8);
  endtask

  task automatic request_pulse(input int bitpos, input int limit);
    @(posedge coreclk_fanout_clk);
    reset_req[bitpos] <= 1'b1;
    wait_pulse(bitpos, 1'b1, 5);
    wait_pulse(bitpos, 1'b0, limit);
    @(posedge coreclk_fanout_clk);
    reset_req[bitpos] <= 1'b0;
    repeat (5) @(posedge coreclk_fanout_clk);
  endtask

  initial begin
    logic [31:0] r;
    int errors;
    coreclk_fanout_clk     = 1'b0;
    coreclk_fanout_reset_n = 1'b0;
    buttons_n              = '1;
    reset_req              = '0;
    ltssm_state            = 5'h0f;
    seed                   = 32'd64;
    timeouts               = 0;

    repeat (3) @(posedge coreclk_fanout_clk);
    coreclk_fanout_reset_n <= 1'b1;
    repeat (4) @(posedge coreclk_fanout_clk);

    // held presses and releases
    for (int k = 0; k < 6; k++) begin
      next_rand(r);
      hold_press(r[3:0] | 4'b0001);
      hold_press('0);
    end

    // short glitches from released, must be absorbed
    for (int k = 0; k < 10; k++) begin
      next_rand(r);
      @(posedge coreclk_fanout_clk);
      buttons_n <= ~(r[3:0] | 4'b0010);
      repeat (1 + int'(r[11:8]) % 12) @(posedge coreclk_fanout_clk);
      buttons_n <= '1;
      repeat (20) @(posedge coreclk_fanout_clk);
    end
    wait_buttons('0, 4);

    // one pulse per field, struct bit 2 cold, 1 warm, 0 debug
    request_pulse(2, 12);
    request_pulse(1, 8);
    request_pulse(0, 40);

    // second debug edge while the pulse runs
    @(posedge coreclk_fanout_clk);
    reset_req.debug <= 1'b1;
    wait_pulse(0, 1'b1, 5);
    @(posedge coreclk_fanout_clk);
    reset_req.debug <= 1'b0;
    repeat (3) @(posedge coreclk_fanout_clk);
    reset_req.debug <= 1'b1;
    wait_pulse(0, 1'b0, 40);
    repeat (10) @(posedge coreclk_fanout_clk);
    reset_req.debug <= 1'b0;

    // random ltssm, every fourth one in L0
    for (int k = 0; k < 30; k++) begin
      next_rand(r);
      @(posedge coreclk_fanout_clk);
      ltssm_state <= (k % 4 == 0) ? {r[4], 4'hf} : r[4:0];
      repeat (int'(r[9:8])) @(posedge coreclk_fanout_clk);
    end

    // run past a full timer wrap for bank and heartbeat
    repeat (4200) @(posedge coreclk_fanout_clk);

    errors = u_checker.error_count + timeouts;
    $display("checks %0d, check errors %0d, timeouts %0d, pulses %0d/%0d/%0d",
             u_checker.check_count, u_checker.error_count, timeouts,
             u_checker.pulse_count[0], u_checker.pulse_count[1],
             u_checker.pulse_count[2]);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
